// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // plain 32-bit words
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // first pc fetched after reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

    // redirects from writeback, each valid is a one-cycle pulse
    typedef struct packed {
        logic  ertn_valid;
        addr_t ertn_target;
        logic  ex_valid;
        addr_t ex_entry;
        logic  refetch_valid;
        // refetch resumes at wb_pc + 4
        addr_t wb_pc;
    } redirect_t;

    // branch resolution from decode
    typedef struct packed {
        logic  taken;
        logic  stall;
        addr_t target;
    } branch_t;

    // payload handed to decode
    typedef struct packed {
        inst_t inst;
        addr_t pc;
    } fetch_out_t;

    // fetch exceptions
    typedef struct packed {
        // misaligned pc
        logic adef;
        // translation miss
        logic tlbr;
    } fetch_excep_t;

endpackage

`default_nettype wire

// ==== design/inst_xlate.sv ====
`default_nettype none

module inst_xlate (
    input  wire fetch_pkg::addr_t inst_va,
    input  wire [2:0]             win_vseg,
    input  wire [2:0]             win_pseg,
    output wire fetch_pkg::addr_t inst_pa,
    output wire                   tlb_miss
);
    logic [2:0]  va_seg;
    logic [28:0] va_offset;
    logic        win_hit;

    // one direct window over a 512 MB segment
    assign va_seg    = inst_va[31:29];
    assign va_offset = inst_va[28:0];
    assign win_hit   = (va_seg == win_vseg);

    // a miss passes the address through untouched
    assign inst_pa  = win_hit ? {win_pseg, va_offset} : inst_va;
    assign tlb_miss = ~win_hit;

endmodule

`default_nettype wire

// ==== design/inst_sram.sv ====
`default_nettype none

module inst_sram #(
    parameter int DEPTH_LOG2 = 10,
    // cycles from acceptance to data_ok, at least 1
    parameter int LATENCY    = 2
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   req,
    input  wire fetch_pkg::addr_t addr,
    output wire                   addr_ok,
    output wire                   data_ok,
    output wire fetch_pkg::inst_t rdata,
    input  wire                   load_en,
    input  wire fetch_pkg::addr_t load_addr,
    input  wire fetch_pkg::inst_t load_data
);
    import fetch_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam int CNT_W = $clog2(LATENCY + 2);

    typedef logic [DEPTH_LOG2-1:0] word_idx_t;
    typedef logic [CNT_W-1:0]      cnt_t;

    localparam cnt_t MAX_OUT = cnt_t'(LATENCY + 1);

    inst_t              mem [DEPTH];
    logic               accept;
    logic [LATENCY-1:0] pipe_vld;
    word_idx_t          pipe_idx [LATENCY];
    cnt_t               outstanding;

    assign accept  = req & addr_ok;
    assign addr_ok = outstanding < MAX_OUT;
    assign data_ok = pipe_vld[LATENCY-1];
    assign rdata   = mem[pipe_idx[LATENCY-1]];

    // word-indexed, byte offset ignored
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[DEPTH_LOG2+1:2]] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld[0] <= accept;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_vld[i] <= pipe_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_idx[0] <= addr[DEPTH_LOG2+1:2];
        for (int i = 1; i < LATENCY; i++) begin
            pipe_idx[i] <= pipe_idx[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + cnt_t'(accept) - cnt_t'(data_ok);
        end
    end

    // each response must match an earlier acceptance
    assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> (outstanding != '0));

endmodule

`default_nettype wire

// ==== fetch/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          id_allowin,
    input  wire fetch_pkg::branch_t      branch,
    input  wire fetch_pkg::redirect_t    redirect,
    output wire fetch_pkg::addr_t        inst_va,
    input  wire                          tlb_miss,
    output wire                          inst_sram_req,
    input  wire                          inst_sram_addr_ok,
    input  wire                          inst_sram_data_ok,
    input  wire fetch_pkg::inst_t        inst_sram_rdata,
    output wire                          if_to_id_valid,
    output wire fetch_pkg::fetch_out_t   if_to_id_data,
    output wire fetch_pkg::fetch_excep_t if_to_id_excep
);
    import fetch_pkg::*;

    // redirect sources, index 0 has the highest priority
    localparam int NUM_REDIR = 4;

    logic [NUM_REDIR-1:0] redir_live;
    addr_t                redir_tgt [NUM_REDIR];
    logic [NUM_REDIR-1:0] redir_pend;
    addr_t                redir_pend_tgt [NUM_REDIR];
    logic                 wb_flush;

    addr_t                if_pc;
    addr_t                seq_pc;
    addr_t                nextpc;
    fetch_excep_t         next_excep;
    logic                 if_valid;
    fetch_excep_t         if_excep;
    logic                 if_has_excep;
    logic                 if_ready_go;
    logic                 if_allowin;
    logic                 slot_kill;
    logic                 accept;

    logic                 buf_valid;
    inst_t                buf_inst;
    logic                 resp_live;

    logic [3:0]           cancel_cnt;
    logic                 inst_cancel;
    logic                 cancel_inc;
    logic                 cancel_dec;
    logic                 preif_cancel;

    assign redir_live[0] = redirect.ertn_valid;
    assign redir_live[1] = redirect.ex_valid;
    assign redir_live[2] = redirect.refetch_valid;
    assign redir_live[3] = branch.taken;
    assign redir_tgt[0]  = redirect.ertn_target;
    assign redir_tgt[1]  = redirect.ex_entry;
    assign redir_tgt[2]  = redirect.wb_pc + 32'd4;
    assign redir_tgt[3]  = branch.target;

    // writeback redirects flush the slot even if decode is ready
    assign wb_flush = |redir_live[2:0];

    assign seq_pc = if_pc + 32'd4;

    // latched copy of a source beats its live copy
    always_comb begin
        nextpc = seq_pc;
        for (int i = NUM_REDIR - 1; i >= 0; i--) begin
            if (redir_live[i]) begin
                nextpc = redir_tgt[i];
            end
            if (redir_pend[i]) begin
                nextpc = redir_pend_tgt[i];
            end
        end
    end

    assign inst_va    = nextpc;
    assign next_excep = '{adef: |nextpc[1:0], tlbr: tlb_miss};

    // response that belongs to the entry in the slot
    assign resp_live    = inst_sram_data_ok & ~inst_cancel & ~preif_cancel;
    assign if_has_excep = if_excep.adef | if_excep.tlbr;
    assign if_ready_go  = if_has_excep | buf_valid | resp_live;

    assign if_to_id_valid = if_valid & if_ready_go & ~wb_flush;
    assign slot_kill      = if_valid & (|redir_live) & ~(if_to_id_valid & id_allowin);
    assign if_allowin     = ~if_valid | (if_to_id_valid & id_allowin) | slot_kill;

    assign inst_sram_req = if_allowin & ~branch.stall & ~preif_cancel;
    assign accept        = inst_sram_req & inst_sram_addr_ok;

    // a killed entry still waiting leaves one response to drop
    assign inst_cancel = |cancel_cnt;
    assign cancel_inc  = slot_kill & ~if_ready_go;
    assign cancel_dec  = inst_sram_data_ok & inst_cancel;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            redir_pend <= '0;
        end else if (accept) begin
            redir_pend <= '0;
        end else begin
            redir_pend <= redir_pend | redir_live;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REDIR; i++) begin
            if (redir_live[i]) begin
                redir_pend_tgt[i] <= redir_tgt[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_pc <= RESET_PC - 32'd4;
        end else if (accept) begin
            if_pc <= nextpc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
        end else if (if_allowin) begin
            if_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if_excep <= next_excep;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= '0;
        end else begin
            cancel_cnt <= cancel_cnt + {3'b0, cancel_inc} - {3'b0, cancel_dec};
        end
    end

    // the memory answers exception fetches too, hold issue until that word is gone
    always_ff @(posedge clk) begin
        if (!resetn) begin
            preif_cancel <= 1'b0;
        end else if (accept & (next_excep.adef | next_excep.tlbr)) begin
            preif_cancel <= 1'b1;
        end else if (inst_sram_data_ok & ~inst_cancel) begin
            preif_cancel <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (if_allowin) begin
            buf_valid <= 1'b0;
        end else if (resp_live & if_valid) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!buf_valid & resp_live) begin
            buf_inst <= inst_sram_rdata;
        end
    end

    assign if_to_id_data  = '{inst: buf_valid ? buf_inst : inst_sram_rdata, pc: if_pc};
    assign if_to_id_excep = if_excep;

    // more kills than responses in flight would overflow the drop count
    assert property (@(posedge clk) disable iff (!resetn)
        (cancel_cnt == '1) |-> !(cancel_inc && !cancel_dec));

    assert property (@(posedge clk) !resetn |=> !if_to_id_valid);

endmodule

`default_nettype wire

// ==== design/fetch_unit_top.sv ====
`default_nettype none

module fetch_unit_top #(
    parameter int DEPTH_LOG2 = 10,
    parameter int LATENCY    = 2
) (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          id_allowin,
    input  wire fetch_pkg::branch_t      branch,
    input  wire fetch_pkg::redirect_t    redirect,
    input  wire                          load_en,
    input  wire fetch_pkg::addr_t        load_addr,
    input  wire fetch_pkg::inst_t        load_data,
    input  wire [2:0]                    win_vseg,
    input  wire [2:0]                    win_pseg,
    output wire                          if_to_id_valid,
    output wire fetch_pkg::fetch_out_t   if_to_id_data,
    output wire fetch_pkg::fetch_excep_t if_to_id_excep
);
    import fetch_pkg::*;

    addr_t inst_va;
    addr_t inst_pa;
    logic  tlb_miss;
    logic  inst_sram_req;
    logic  inst_sram_addr_ok;
    logic  inst_sram_data_ok;
    inst_t inst_sram_rdata;

    fetch_stage fetch_stage_i (
        .clk               (clk),
        .resetn            (resetn),
        .id_allowin        (id_allowin),
        .branch            (branch),
        .redirect          (redirect),
        .inst_va           (inst_va),
        .tlb_miss          (tlb_miss),
        .inst_sram_req     (inst_sram_req),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata),
        .if_to_id_valid    (if_to_id_valid),
        .if_to_id_data     (if_to_id_data),
        .if_to_id_excep    (if_to_id_excep)
    );

    inst_xlate inst_xlate_i (
        .inst_va  (inst_va),
        .win_vseg (win_vseg),
        .win_pseg (win_pseg),
        .inst_pa  (inst_pa),
        .tlb_miss (tlb_miss)
    );

    // request address is the translated fetch pc
    inst_sram #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .LATENCY    (LATENCY)
    ) inst_sram_i (
        .clk       (clk),
        .resetn    (resetn),
        .req       (inst_sram_req),
        .addr      (inst_pa),
        .addr_ok   (inst_sram_addr_ok),
        .data_ok   (inst_sram_data_ok),
        .rdata     (inst_sram_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// ==== test/fetch_tb_tasks.svh ====
`ifndef FETCH_TB_TASKS_SVH
`define FETCH_TB_TASKS_SVH

// one word per cycle, each word is its own physical address inverted
task automatic load_memory();
    addr_t base;
    int    i;
    base = expected_pa(RESET_PC) & ~((32'd1 << (DEPTH_LOG2 + 2)) - 32'd1);
    for (i = 0; i < LOAD_CYCLES; i++) begin
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = base + 32'(4 * i);
        load_data = ~(base + 32'(4 * i));
    end
    @(negedge clk);
    load_en = 1'b0;
endtask

task automatic wait_for_transfers(input int count, input string what);
    int cycles;
    int limit;
    cycles = 0;
    limit  = (count - got_pc.size()) * (LATENCY + 4) * 4 + 20;
    while (got_pc.size() < count && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    checks++;
    assert (got_pc.size() >= count) else begin
        errors++;
        $display("%s: decode received %0d of %0d transfers before giving up",
                 what, got_pc.size(), count);
    end
endtask

// pulse a redirect mid-stream, then expect target, target+4, target+8
task automatic redirect_and_check(input branch_t br, input redirect_t rd,
                                  input addr_t target, input string what);
    int    base;
    int    k;
    addr_t last;
    @(negedge clk);
    base     = got_pc.size();
    last     = got_pc[base-1];
    branch   = br;
    redirect = rd;
    @(negedge clk);
    branch   = '0;
    redirect = '0;
    wait_for_transfers(base + 4, what);
    if (got_pc.size() < base + 4) begin
        return;
    end
    k = base;
    // the entry already fetched may still go through
    if (got_pc[k] == last + 32'd4) begin
        k++;
    end
    check_word("if_to_id_data.pc", got_pc[k], target);
    check_word("if_to_id_data.pc", got_pc[k+1], target + 32'd4);
    check_word("if_to_id_data.pc", got_pc[k+2], target + 32'd8);
endtask

task automatic sequential_fetch();
    int k;
    @(negedge clk);
    id_allowin   = 1'b1;
    branch.stall = 1'b0;
    wait_for_transfers(16, "sequential fetch");
    for (k = 0; k < 16 && k < got_pc.size(); k++) begin
        check_word("if_to_id_data.pc", got_pc[k], RESET_PC + 32'(4 * k));
    end
endtask

task automatic branch_redirect();
    branch_t br;
    br        = '0;
    br.taken  = 1'b1;
    br.target = 32'h1c00_0400;
    redirect_and_check(br, '0, br.target, "branch redirect");
endtask

task automatic redirect_priority();
    branch_t   br;
    redirect_t rd;
    br        = '0;
    br.taken  = 1'b1;
    br.target = 32'h1c00_0300;
    rd               = '0;
    rd.ertn_valid    = 1'b1;
    rd.ertn_target   = 32'h1c00_0600;
    rd.ex_valid      = 1'b1;
    rd.ex_entry      = 32'h1c00_0700;
    rd.refetch_valid = 1'b1;
    rd.wb_pc         = 32'h1c00_07f0;
    redirect_and_check(br, rd, rd.ertn_target, "ertn priority");
    rd.ertn_valid = 1'b0;
    redirect_and_check(br, rd, rd.ex_entry, "exception priority");
    rd.ex_valid = 1'b0;
    redirect_and_check(br, rd, rd.wb_pc + 32'd4, "refetch priority");
endtask

task automatic backpressure_stream();
    int    base;
    int    k;
    int    cycles;
    addr_t last;
    @(negedge clk);
    base   = got_pc.size();
    last   = got_pc[base-1];
    cycles = 0;
    while (got_pc.size() < base + 40 && cycles < 40 * (LATENCY + 4) * 4) begin
        lfsr_state = lfsr_step(lfsr_state);
        id_allowin = lfsr_state[0];
        @(negedge clk);
        cycles++;
    end
    id_allowin = 1'b1;
    checks++;
    assert (got_pc.size() >= base + 40) else begin
        errors++;
        $display("back-pressure: the stream stopped after %0d transfers", got_pc.size() - base);
    end
    for (k = 0; k < 40 && base + k < got_pc.size(); k++) begin
        check_word("if_to_id_data.pc", got_pc[base+k], last + 32'(4 * (k + 1)));
    end
endtask

task automatic fetch_exceptions();
    branch_t   br;
    redirect_t rd;
    br        = '0;
    br.taken  = 1'b1;
    br.target = 32'h1c00_0902;
    redirect_and_check(br, '0, br.target, "misaligned branch");
    br.target = 32'h5c00_0100;
    redirect_and_check(br, '0, br.target, "branch outside the window");
    // back onto the mapped path through an exception entry
    rd          = '0;
    rd.ex_valid = 1'b1;
    rd.ex_entry = 32'h1c00_0a00;
    redirect_and_check('0, rd, rd.ex_entry, "exception entry");
endtask

`endif

// ==== test/fetch_tb.sv ====
`default_nettype none

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam int DEPTH_LOG2  = 10;
    localparam int LATENCY     = 2;
    localparam int LOAD_CYCLES = 1 << DEPTH_LOG2;
    // sixteen sequential plus four per redirect plus forty under back-pressure
    localparam int TOTAL_XFERS = 16 + 7 * 4 + 40;
    localparam int WATCHDOG_NS = (LOAD_CYCLES + 10) * 10
                               + TOTAL_XFERS * (LATENCY + 4) * 10 + 5000;

    logic         clk;
    logic         resetn;
    logic         id_allowin;
    branch_t      branch;
    redirect_t    redirect;
    logic         load_en;
    addr_t        load_addr;
    inst_t        load_data;
    logic [2:0]   win_vseg;
    logic [2:0]   win_pseg;
    logic         if_to_id_valid;
    fetch_out_t   if_to_id_data;
    fetch_excep_t if_to_id_excep;

    int           errors;
    int           checks;
    logic [31:0]  lfsr_state;

    // transfers seen by the decode-side model
    addr_t        got_pc [$];

    logic         hold_prev;
    fetch_out_t   held_data;
    logic         reset_prev;

    fetch_unit_top #(
        .DEPTH_LOG2 (DEPTH_LOG2),
        .LATENCY    (LATENCY)
    ) fetch_unit_top_i (
        .clk            (clk),
        .resetn         (resetn),
        .id_allowin     (id_allowin),
        .branch         (branch),
        .redirect       (redirect),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .win_vseg       (win_vseg),
        .win_pseg       (win_pseg),
        .if_to_id_valid (if_to_id_valid),
        .if_to_id_data  (if_to_id_data),
        .if_to_id_excep (if_to_id_excep)
    );

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // top three bits swap to the physical segment on a window hit
    function automatic addr_t expected_pa(input addr_t va);
        if (va[31:29] == win_vseg) begin
            return {win_pseg, va[28:0]};
        end
        return va;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    `include "fetch_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // decode-side model samples at the rising edge
    always @(posedge clk) begin : decode_model
        logic redir_now;
        logic exp_adef;
        logic exp_tlbr;
        redir_now = branch.taken | redirect.ertn_valid | redirect.ex_valid
                  | redirect.refetch_valid;
        if (!resetn) begin
            // outputs are unknown until the first reset edge
            if (reset_prev) begin
                check_word("if_to_id_valid", if_to_id_valid, 1'b0);
            end
        end else begin
            if (hold_prev && !redir_now) begin
                check_word("if_to_id_valid", if_to_id_valid, 1'b1);
                check_word("if_to_id_data.pc", if_to_id_data.pc, held_data.pc);
                check_word("if_to_id_data.inst", if_to_id_data.inst, held_data.inst);
            end
            if (if_to_id_valid && id_allowin) begin
                exp_adef = |if_to_id_data.pc[1:0];
                exp_tlbr = if_to_id_data.pc[31:29] != win_vseg;
                check_word("if_to_id_excep.adef", if_to_id_excep.adef, exp_adef);
                check_word("if_to_id_excep.tlbr", if_to_id_excep.tlbr, exp_tlbr);
                if (!exp_adef && !exp_tlbr) begin
                    check_word("if_to_id_data.inst", if_to_id_data.inst,
                               ~expected_pa(if_to_id_data.pc));
                end
                got_pc.push_back(if_to_id_data.pc);
            end
        end
        hold_prev  = resetn & if_to_id_valid & ~id_allowin & ~redir_now;
        held_data  = if_to_id_data;
        reset_prev = ~resetn;
    end

    initial begin
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'h98b3;
        hold_prev  = 1'b0;
        reset_prev = 1'b0;
        resetn     = 1'b0;
        id_allowin = 1'b0;
        redirect   = '0;
        branch     = '0;
        // hold issue off until the memory is loaded
        branch.stall = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        win_vseg   = 3'd0;
        win_pseg   = 3'd1;
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        load_memory();
        sequential_fetch();
        branch_redirect();
        redirect_priority();
        backpressure_stream();
        fetch_exceptions();
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+test
common/fetch_pkg.sv
design/inst_xlate.sv
design/inst_sram.sv
fetch/fetch_stage.sv
design/fetch_unit_top.sv
test/fetch_tb.sv
